//--- list.f
source/regPkg.sv
source/uopPkg.sv
source/laneRegFile.sv
source/laneDataMem.sv
source/exLaneStage1.sv
source/exLaneStage2.sv
source/exLaneStage3.sv
source/exLaneTop.sv
verification/exLaneTb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= list.f
TB_TOP ?= exLaneTb
RTL_TOP ?= exLaneTop
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/exLaneTb.sv
// Directed testbench for the execute lane, checked against a reference model
module exLaneTb;
	timeunit 1ns;
	timeprecision 100ps;
	import uopPkg::*;
	import regPkg::*;

	logic clock = 1'b0;
	logic rstN;
	uop issueUop;
	logic braFlush;
	laneWb wb;
	logic srT;
	regVal modelRegs [regCount];			// Expected register contents
	regVal modelMem [memWords];			// Expected memory words
	logic modelT;					// Expected status bit
	logic [31:0] rngState = 32'hee30;		// Xorshift state

	exLaneTop u_dut (.*);

	always #20 clock = ~clock;			// 40 ns period

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] randomWord();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic uop makeUop(uCmd cmd, uPred pred, logic [2:0] sel, regId rs, regId rt,
			regId rm, logic [32:0] imm);
		return {cmd, pred, 5'b00000, sel, rs, rt, rm, imm};	// Uop field order
	endfunction

	task automatic failRun(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			failRun($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// Applies one uop to the model and predicts its writeback
	task automatic modelOp(uop u, output logic expValid, output regVal expVal);
		regVal a;
		regVal b;
		regVal imm;
		regVal addr;
		logic en;
		a = modelRegs[u.rs];
		b = modelRegs[u.rt];
		imm = {{31{u.imm[32]}}, u.imm};		// Sign extend 33 bits
		addr = a + imm;				// Only low word bits used
		en = u.pred[1] ? (modelT ^ u.pred[0]) : !u.pred[0];	// Always, never, T, not T
		expVal = imm;
		if (en && u.cmd == ucAlu3) begin
			case (u.ixt.alu.op)
				aluAdd: expVal = a + b;
				aluSub: expVal = a - b;
				aluAnd: expVal = a & b;
				aluOr: expVal = a | b;
				default: expVal = a ^ b;
			endcase
		end else if (en && u.cmd == ucAluCmp) begin
			case (u.ixt.cmp.cond)
				cmpEq: modelT = a == b;
				cmpGt: modelT = $signed(a) > $signed(b);
				default: modelT = a > b;	// Unsigned
			endcase
		end else if (en && u.cmd == ucMovRm) begin
			modelMem[addr[5:0]] = modelRegs[u.rm];
		end else if (en && u.cmd == ucMovMr) begin
			expVal = modelMem[addr[5:0]];
		end
		expValid = en && u.cmd inside {ucMovIr, ucAlu3, ucMovMr};
		if (expValid) begin
			modelRegs[u.rm] = expVal;
		end
	endtask

	task automatic issueOp(uop u);
		@(posedge clock);
		issueUop <= u;
		@(posedge clock);
		issueUop <= '0;				// Idle again
	endtask

	// Writeback expected two cycles after issue or not at all
	task automatic awaitResult(string name, logic expValid, regId expId, regVal expVal);
		int n;
		n = 0;
		if (expValid) begin
			do begin
				@(negedge clock);		// Mid cycle where outputs are settled
				n++;
			end while (!wb.valid && n < 8);
			if (!wb.valid) begin
				failRun($sformatf("%s: no writeback arrived within 8 cycles", name));
			end else begin
				check({name, " latency"}, 2, 64'(n));
				check({name, " id"}, 64'(expId), 64'(wb.id));
				check(name, expVal, wb.value);
			end
		end else begin
			for (n = 0; n < 2; n++) begin
				@(negedge clock);
				check({name, " no writeback"}, 0, 64'(wb.valid));
			end
		end
		check({name, " srT"}, 64'(modelT), 64'(srT));
	endtask

	task automatic runOp(string name, uop u);
		logic expValid;
		regVal expVal;
		modelOp(u, expValid, expVal);
		issueOp(u);
		awaitResult(name, expValid, u.rm, expVal);
	endtask

	// One cycle of drive in which no writeback may appear
	task automatic stepQuiet(string name, uop u, logic flush);
		@(posedge clock);
		issueUop <= u;
		braFlush <= flush;
		@(negedge clock);
		check({name, " no writeback"}, 0, 64'(wb.valid));
	endtask

	task automatic testReset();
		@(negedge clock);
		check("reset wb valid", 0, 64'(wb.valid));
		check("reset srT", 0, 64'(srT));
		runOp("reset add", makeUop(ucAlu3, predAlways, aluAdd, 6'd5, 6'd6, 6'd7, '0));
	endtask

	task automatic testAluOps();
		for (int i = 1; i <= 4; i++) begin
			runOp("alu setup", makeUop(ucMovIr, predAlways, '0, '0, '0, regId'(i),
					{i[0], randomWord()}));
		end
		for (int op = 0; op < 5; op++) begin
			runOp("alu r1 r2", makeUop(ucAlu3, predAlways, 3'(op), 6'd1, 6'd2,
					regId'(10 + op), '0));
			runOp("alu r3 r4", makeUop(ucAlu3, predAlways, 3'(op), 6'd3, 6'd4,
					regId'(16 + op), '0));
		end
	endtask

	task automatic testPredication();
		uop cmpOp;
		uop movOp;
		logic expValid;
		regVal expVal;
		runOp("pred r20", makeUop(ucMovIr, predAlways, '0, '0, '0, 6'd20, 33'd5));
		runOp("pred r21", makeUop(ucMovIr, predAlways, '0, '0, '0, 6'd21, 33'd9));
		runOp("pred r22", makeUop(ucMovIr, predAlways, '0, '0, '0, 6'd22, '1));	// Minus one
		for (int k = 0; k < 4; k++) begin
			case (k)
				0: runOp("cmp eq",
						makeUop(ucAluCmp, predAlways, cmpEq, 6'd20, 6'd20, '0, '0));
				1: runOp("cmp gt",
						makeUop(ucAluCmp, predAlways, cmpGt, 6'd20, 6'd21, '0, '0));
				2: runOp("cmp hi",
						makeUop(ucAluCmp, predAlways, cmpHi, 6'd22, 6'd20, '0, '0));
				default: runOp("cmp gt neg",
						makeUop(ucAluCmp, predAlways, cmpGt, 6'd22, 6'd20, '0, '0));
			endcase
			for (int p = 0; p < 4; p++) begin
				runOp("pred move", makeUop(ucMovIr, uPred'(p), '0, '0, '0, regId'(30 + p),
						33'(k * 4 + p + 1)));
			end
		end
		// T is clear here so the move only runs if it sees the new T
		cmpOp = makeUop(ucAluCmp, predAlways, cmpEq, 6'd20, 6'd20, '0, '0);
		movOp = makeUop(ucMovIr, predIfT, '0, '0, '0, 6'd34, 33'd77);
		modelOp(cmpOp, expValid, expVal);
		modelOp(movOp, expValid, expVal);
		@(posedge clock);
		issueUop <= cmpOp;
		issueOp(movOp);				// Next cycle
		awaitResult("pred back to back", expValid, movOp.rm, expVal);
		runOp("pred cmp skipped", makeUop(ucAluCmp, predIfNotT, cmpGt, 6'd20, 6'd21, '0, '0));
	endtask

	task automatic testLoadStore();
		runOp("ls base", makeUop(ucMovIr, predAlways, '0, '0, '0, 6'd50,
				33'(randomWord() % 32'd64)));
		for (int i = 0; i < 4; i++) begin
			runOp("ls data", makeUop(ucMovIr, predAlways, '0, '0, '0, regId'(40 + i),
					{1'b1, randomWord()}));
			runOp("ls store", makeUop(ucMovRm, predAlways, '0, 6'd50, '0, regId'(40 + i),
					33'(i * 7) - 33'd3));
		end
		for (int i = 0; i < 4; i++) begin
			runOp("ls load", makeUop(ucMovMr, predAlways, '0, 6'd50, '0, regId'(44 + i),
					33'(i * 7) - 33'd3));
		end
	endtask

	// Flush in the third and fourth cycle kills both ALU ops and the store
	task automatic testFlush();
		stepQuiet("flush add", makeUop(ucAlu3, predAlways, aluAdd, 6'd1, 6'd2, 6'd60, '0),
				1'b0);
		stepQuiet("flush xor", makeUop(ucAlu3, predAlways, aluXor, 6'd3, 6'd4, 6'd61, '0),
				1'b0);
		stepQuiet("flush store", makeUop(ucMovRm, predAlways, '0, 6'd50, '0, 6'd1, 33'd4),
				1'b1);
		stepQuiet("flush hold", '0, 1'b1);
		stepQuiet("flush drain", '0, 1'b0);
		stepQuiet("flush drain", '0, 1'b0);
		runOp("flush load",
				makeUop(ucMovMr, predAlways, '0, 6'd50, '0, 6'd62, 33'd4));	// Old word
		runOp("flush r60 kept", makeUop(ucAlu3, predAlways, aluOr, 6'd60, 6'd60, 6'd63, '0));
		runOp("flush r61 kept", makeUop(ucAlu3, predAlways, aluOr, 6'd61, 6'd61, 6'd63, '0));
	endtask

	task automatic testRandomStream();
		logic [31:0] r;
		uCmd cmd;
		logic [2:0] sel;
		for (int i = 0; i < 40; i++) begin
			r = randomWord();
			case (r[1:0])
				2'd1: cmd = ucAlu3;
				2'd2: cmd = ucAluCmp;
				default: cmd = ucMovIr;	// Moves twice as often
			endcase
			sel = (cmd == ucAluCmp) ? r[6:4] % 3'd3 : r[6:4] % 3'd5;
			runOp("random", makeUop(cmd, uPred'(r[3:2]), sel, {2'b00, r[10:7]}, {2'b00, r[14:11]},
					{2'b00, r[18:15]}, {r[19], randomWord()}));
		end
	endtask

	initial begin
		rstN = 1'b0;
		issueUop = '0;
		braFlush = 1'b0;
		modelT = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < memWords; i++) begin
			modelMem[i] = '0;
		end
		repeat (3) @(posedge clock);
		rstN <= 1'b1;
		testReset();
		testAluOps();
		testPredication();
		testLoadStore();
		testFlush();
		testRandomStream();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- source/exLaneTop.sv
// Secondary execute lane top, joining register file, EX1 to EX3 and data memory
module exLaneTop (
	input  logic clock,
	input  logic rstN,
	input  uopPkg::uop issueUop,
	input  logic braFlush,
	output regPkg::laneWb wb,
	output logic srT
);
	import regPkg::*;

	regVal valRs;
	regVal valRt;
	regVal valRm;
	destWrite ex1Dest;				// EX1 to EX2
	destWrite ex2Dest;				// EX2 to EX3
	logic ex1Load;
	logic ex2Load;
	memAddr ex1Addr;
	logic ex1We;
	regVal ex1WData;
	regVal memRData;				// Load data into EX3

	laneRegFile u_regFile (
		.clock (clock),
		.rstN (rstN),
		.rdIdA (issueUop.rs),
		.rdIdB (issueUop.rt),
		.rdIdC (issueUop.rm),
		.rdValA (valRs),
		.rdValB (valRt),
		.rdValC (valRm),
		.wr (wb)
	);

	exLaneStage1 u_ex1 (
		.clock (clock),
		.rstN (rstN),
		.issueUop (issueUop),
		.valRs (valRs),
		.valRt (valRt),
		.valRm (valRm),
		.braFlush (braFlush),
		.dest (ex1Dest),
		.loadPend (ex1Load),
		.memAddr (ex1Addr),
		.memWe (ex1We),
		.memWData (ex1WData),
		.srT (srT)
	);

	exLaneStage2 u_ex2 (
		.clock (clock),
		.rstN (rstN),
		.braFlush (braFlush),
		.destIn (ex1Dest),
		.loadIn (ex1Load),
		.destOut (ex2Dest),
		.loadOut (ex2Load)
	);

	laneDataMem u_dataMem (
		.clock (clock),
		.rstN (rstN),
		.addr (ex1Addr),
		.we (ex1We),
		.wData (ex1WData),
		.rData (memRData)
	);

	exLaneStage3 u_ex3 (
		.dest (ex2Dest),
		.load (ex2Load),
		.memRData (memRData),
		.wb (wb)
	);

endmodule

//--- source/exLaneStage3.sv
// EX3 stage that forwards the EX2 destination or substitutes load data to form the writeback
module exLaneStage3 (
	input  regPkg::destWrite dest,
	input  logic load,
	input  regPkg::regVal memRData,
	output regPkg::laneWb wb
);

	always_comb begin
		wb = dest;				// Forward by default
		if (load) begin
			wb.value = memRData;		// Rm id kept from EX1
		end
	end

	// Memory and EX2 must both deliver settled data for a live writeback
	always_comb begin
		if (wb.valid) begin
			assert (!$isunknown(wb))
				else $error("EX3 writeback has unknown bits");
		end
	end

endmodule

//--- source/exLaneStage2.sv
// EX2 stage that carries the destination and load flag, with branch flush kill
module exLaneStage2 (
	input  logic clock,
	input  logic rstN,
	input  logic braFlush,
	input  regPkg::destWrite destIn,
	input  logic loadIn,
	output regPkg::destWrite destOut,
	output logic loadOut
);
	import regPkg::*;

	destWrite destQ;				// Entry held in EX2
	logic loadQ;					// Entry is a load

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			destQ <= '0;
			loadQ <= 1'b0;
		end else begin
			destQ <= destIn;
			loadQ <= loadIn;
		end
	end

	// Flush kills the op sitting here this cycle
	always_comb begin
		destOut = destQ;
		destOut.valid = destQ.valid && !braFlush;
		loadOut = loadQ && !braFlush;
	end

	// EX1 always tags a load with its Rm destination
	assert property (@(posedge clock) disable iff (!rstN) loadQ |-> destQ.valid)
		else $error("EX2 load entry without a valid destination");

endmodule

//--- source/exLaneStage1.sv
// EX1 stage that captures the uop, applies predicate and flush, and runs ALU, compare and AGU
module exLaneStage1 (
	input  logic clock,
	input  logic rstN,
	input  uopPkg::uop issueUop,
	input  regPkg::regVal valRs,
	input  regPkg::regVal valRt,
	input  regPkg::regVal valRm,
	input  logic braFlush,
	output regPkg::destWrite dest,
	output logic loadPend,
	output regPkg::memAddr memAddr,
	output logic memWe,
	output regPkg::regVal memWData,
	output logic srT
);
	import uopPkg::*;
	import regPkg::*;

	uop uopQ;					// Uop held in EX1
	regVal rsQ;					// Operand A
	regVal rtQ;					// Operand B
	regVal rmQ;					// Store data
	logic tQ;					// Status T bit
	logic opEn;					// Predicate holds and no flush
	uCmd cmdEn;					// Command after demotion
	regVal immExt;
	regVal aluRes;
	logic cmpRes;
	regVal addrSum;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			uopQ <= '0;			// Empty slot is a NOP
		end else begin
			uopQ <= issueUop;
		end
	end

	always_ff @(posedge clock) begin
		rsQ <= valRs;
		rtQ <= valRt;
		rmQ <= valRm;
	end

	always_comb begin
		opEn = opEnabled(uopQ.pred, tQ) && !braFlush;
		cmdEn = opEn ? uopQ.cmd : ucNop;	// Disabled ops become NOP
	end

	assign immExt = {{31{uopQ.imm[32]}}, uopQ.imm};
	assign addrSum = rsQ + immExt;			// Base plus displacement

	always_comb begin
		case (uopQ.ixt.alu.op)
			aluAdd: aluRes = rsQ + rtQ;
			aluSub: aluRes = rsQ - rtQ;
			aluAnd: aluRes = rsQ & rtQ;
			aluOr: aluRes = rsQ | rtQ;
			aluXor: aluRes = rsQ ^ rtQ;
			default: aluRes = '0;
		endcase
	end

	always_comb begin
		case (uopQ.ixt.cmp.cond)
			cmpEq: cmpRes = rsQ == rtQ;
			cmpGt: cmpRes = $signed(rsQ) > $signed(rtQ);
			cmpHi: cmpRes = rsQ > rtQ;
			default: cmpRes = 1'b0;
		endcase
	end

	always_comb begin
		dest.valid = 1'b0;
		dest.id = uopQ.rm;			// Rm is always the target
		dest.value = aluRes;
		case (cmdEn)
			ucMovIr: begin
				dest.valid = 1'b1;
				dest.value = immExt;
			end
			ucAlu3: dest.valid = 1'b1;
			ucMovMr: dest.valid = 1'b1;	// Value swapped in EX3
			default: dest.valid = 1'b0;
		endcase
	end

	assign loadPend = cmdEn == ucMovMr;
	assign memWe = cmdEn == ucMovRm;
	assign memAddr = addrSum[$clog2(memWords)-1:0];	// Word index wraps
	assign memWData = rmQ;
	assign srT = tQ;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			tQ <= 1'b0;
		end else if (cmdEn == ucAluCmp) begin
			tQ <= cmpRes;			// Seen by the next issued op
		end
	end

	// Issuer must never send an undefined command that passes predication
	assert property (@(posedge clock) disable iff (!rstN)
		opEn |-> uopQ.cmd inside {ucNop, ucMovIr, ucAlu3, ucAluCmp, ucMovRm, ucMovMr})
		else $error("EX1 enabled unknown command %h", uopQ.cmd);

	// Memory access needs a settled word address
	assert property (@(posedge clock) disable iff (!rstN)
		(memWe || loadPend) |-> !$isunknown(memAddr))
		else $error("EX1 drove a memory access with an unknown address");

endmodule

//--- source/laneDataMem.sv
// Lane data memory, synchronous write and one-cycle registered read
module laneDataMem (
	input  logic clock,
	input  logic rstN,
	input  regPkg::memAddr addr,
	input  logic we,
	input  regPkg::regVal wData,
	output regPkg::regVal rData
);
	import regPkg::*;

	regVal mem [memWords];				// Word array

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= '0;		// Starts all zero
			end
		end else if (we) begin
			mem[addr] <= wData;
		end
	end

	// Read data lands one cycle after the address
	always_ff @(posedge clock) begin
		rData <= mem[addr];
	end

endmodule

//--- source/laneRegFile.sv
// Lane register file with three combinational reads and one writeback port
module laneRegFile (
	input  logic clock,
	input  logic rstN,
	input  regPkg::regId rdIdA,
	input  regPkg::regId rdIdB,
	input  regPkg::regId rdIdC,
	output regPkg::regVal rdValA,
	output regPkg::regVal rdValB,
	output regPkg::regVal rdValC,
	input  regPkg::laneWb wr
);
	import regPkg::*;

	regVal regs [regCount];				// Architectural registers

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid) begin
			regs[wr.id] <= wr.value;	// Written from EX3
		end
	end

	// No bypass, a write shows up on the next read
	assign rdValA = regs[rdIdA];			// Rs
	assign rdValB = regs[rdIdB];			// Rt
	assign rdValC = regs[rdIdC];			// Rm, store data

endmodule

//--- source/uopPkg.sv
// Micro-op package with commands, predicates, extension decode and the enable rule
package uopPkg;

	// Micro-op commands
	typedef enum logic [5:0] {
		ucNop		= 6'h00,		// Idle slot
		ucMovIr		= 6'h01,		// Immediate to Rm
		ucAlu3		= 6'h02,		// Rs op Rt to Rm
		ucAluCmp	= 6'h03,		// Rs vs Rt into T
		ucMovRm		= 6'h04,		// Store Rm to mem[Rs+imm]
		ucMovMr		= 6'h05			// Load mem[Rs+imm] to Rm
	} uCmd;

	typedef enum logic [1:0] {
		predAlways	= 2'b00,
		predNever	= 2'b01,
		predIfT		= 2'b10,
		predIfNotT	= 2'b11
	} uPred;

	typedef enum logic [2:0] {
		aluAdd		= 3'd0,
		aluSub		= 3'd1,
		aluAnd		= 3'd2,
		aluOr		= 3'd3,
		aluXor		= 3'd4
	} aluOp;

	typedef enum logic [2:0] {
		cmpEq		= 3'd0,			// Equal
		cmpGt		= 3'd1,			// Signed greater
		cmpHi		= 3'd2			// Unsigned greater
	} cmpCond;

	// Extension byte, read as ALU op or compare condition depending on cmd
	typedef union packed {
		struct packed {
			logic [4:0] pad;
			aluOp op;
		} alu;
		struct packed {
			logic [4:0] pad;
			cmpCond cond;
		} cmp;
	} uopIxt;

	typedef struct packed {
		uCmd cmd;
		uPred pred;
		uopIxt ixt;
		regPkg::regId rs;			// Source A, ALU or base
		regPkg::regId rt;			// Source B, ALU
		regPkg::regId rm;			// Store data or destination
		logic [32:0] imm;			// Sign extended on use
	} uop;

	// Predicate check against the current T bit
	function automatic logic opEnabled(uPred pred, logic t);
		case (pred)
			predAlways: return 1'b1;
			predNever: return 1'b0;
			predIfT: return t;
			default: return !t;		// If not T
		endcase
	endfunction

endpackage

//--- source/regPkg.sv
// Register package with lane register, memory and writeback definitions
package regPkg;

	localparam int regCount = 64;			// Lane register file depth
	localparam int memWords = 64;			// Data memory depth in words

	typedef logic [5:0] regId;			// Register number
	typedef logic [63:0] regVal;			// Register contents

	typedef logic [$clog2(memWords)-1:0] memAddr;	// Word address into data memory

	// Destination write carried down the pipe
	typedef struct packed {
		logic valid;				// Entry writes a register
		regId id;				// Target register
		regVal value;				// Result to write
	} destWrite;

	typedef destWrite laneWb;			// Lane writeback, same layout

endpackage
